// ==== filelist.f ====
rtl/icache_geom_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_array.sv
rtl/icache_lookup_ctrl.sv
rtl/mshr_queue.sv
rtl/icache_responder.sv
rtl/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

// ==== rtl/icache_array.sv ====
// direct mapped, no eviction path; a lookup on the same edge as a fill sees the old contents
module icache_array (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         lookup_in,
  input  icache_geom_pkg::paddr_t      lookup_addr,
  input  logic                         fill_in,
  input  icache_geom_pkg::block_addr_t fill_block,
  input  icache_geom_pkg::line_t       fill_line,
  input  logic                         flush,
  output logic                         hit,
  output icache_geom_pkg::word_t       hit_word
);

  logic [icache_geom_pkg::SETS-1:0] valid_q;
  icache_geom_pkg::tag_t            tags [icache_geom_pkg::SETS];
  icache_geom_pkg::line_t           lines [icache_geom_pkg::SETS];

  icache_geom_pkg::index_t    lk_index;
  icache_geom_pkg::tag_t      lk_tag;
  icache_geom_pkg::word_sel_t lk_sel;
  icache_geom_pkg::index_t    fill_index;

  assign lk_index = lookup_addr[icache_geom_pkg::OFFSET_BITS +: icache_geom_pkg::INDEX_BITS];
  assign lk_tag = lookup_addr[icache_geom_pkg::PADDR_BITS-1 -: icache_geom_pkg::TAG_BITS];
  assign lk_sel = lookup_addr[icache_geom_pkg::WORD_OFFSET_BITS +: icache_geom_pkg::WORD_SEL_BITS];
  assign fill_index = fill_block[icache_geom_pkg::INDEX_BITS-1:0];

  // valid bits and the registered hit flag
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      hit <= 1'b0;
    end else begin
      // flush beats a fill landing on the same edge
      if (flush) begin
        valid_q <= '0;
      end else if (fill_in) begin
        valid_q[fill_index] <= 1'b1;
      end
      if (lookup_in) begin
        hit <= valid_q[lk_index] && (tags[lk_index] == lk_tag);
      end
    end
  end

  // tag and data storage, word picked out at lookup time
  always_ff @(posedge clk_in) begin
    if (fill_in) begin
      tags[fill_index] <= fill_block[icache_geom_pkg::BLOCK_BITS-1:icache_geom_pkg::INDEX_BITS];
      lines[fill_index] <= fill_line;
    end
    if (lookup_in) begin
      hit_word <= lines[lk_index][lk_sel*icache_geom_pkg::WORD_BITS +: icache_geom_pkg::WORD_BITS];
    end
  end

endmodule

// ==== rtl/icache_ctrl_pkg.sv ====
// queue depth and count must stay powers of two so the FIFO pointers wrap on their own
package icache_ctrl_pkg;

  localparam int MSHR_COUNT = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int MSHR_ID_BITS = $clog2(MSHR_COUNT);
  localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

  typedef logic [MSHR_COUNT-1:0] mshr_vec_t;
  typedef logic [MSHR_ID_BITS-1:0] mshr_id_t;
  typedef logic [QUEUE_PTR_BITS-1:0] queue_ptr_t;
  // one extra bit so a full queue can be told from an empty one
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count_t;

  typedef enum logic [2:0] {
    LK_IDLE,
    LK_LOOKUP,
    LK_HIT,
    LK_ALLOC,
    LK_SEND_REQ
  } lookup_state_t;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_HIT,
    RS_DRAIN,
    RS_SEND
  } responder_state_t;

endpackage

// ==== rtl/icache_geom_pkg.sv ====
// byte addresses must be 8-byte aligned since the cache only returns whole 64-bit words
package icache_geom_pkg;

  localparam int PADDR_BITS = 22;
  localparam int LINE_BYTES = 32;
  localparam int WORD_BITS = 64;
  localparam int WORDS_PER_LINE = 4;
  localparam int SETS = 16;

  // address field widths, derived
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int WORD_OFFSET_BITS = $clog2(WORD_BITS / 8);
  localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
  localparam int INDEX_BITS = $clog2(SETS);
  localparam int BLOCK_BITS = PADDR_BITS - OFFSET_BITS;
  localparam int TAG_BITS = BLOCK_BITS - INDEX_BITS;
  localparam int LINE_BITS = LINE_BYTES * 8;

  typedef logic [PADDR_BITS-1:0] paddr_t;
  typedef logic [BLOCK_BITS-1:0] block_addr_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [LINE_BITS-1:0] line_t;

endpackage

// ==== rtl/icache_lookup_ctrl.sv ====
// one request in flight at a time; a flush is taken only while idle and blocks new requests
module icache_lookup_ctrl (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         l0_valid_in,
  input  icache_geom_pkg::paddr_t      l0_addr_in,
  output logic                         l0_ready_out,
  input  logic                         flush_in,
  output logic                         lookup,
  output icache_geom_pkg::paddr_t      lookup_addr,
  output logic                         flush,
  input  logic                         hit,
  input  icache_geom_pkg::word_t       hit_word,
  output logic                         hit_valid,
  output icache_geom_pkg::paddr_t      hit_addr,
  output icache_geom_pkg::word_t       hit_word_out,
  input  logic                         hit_ready,
  input  icache_ctrl_pkg::mshr_vec_t   req_match,
  input  icache_ctrl_pkg::mshr_vec_t   full,
  input  icache_ctrl_pkg::mshr_vec_t   free,
  output icache_ctrl_pkg::mshr_vec_t   alloc,
  output icache_ctrl_pkg::mshr_vec_t   enqueue,
  output icache_geom_pkg::block_addr_t req_block,
  output icache_geom_pkg::word_sel_t   req_word_sel,
  output logic                         lc_valid_out,
  output icache_geom_pkg::paddr_t      lc_addr_out,
  input  logic                         lc_ready_in
);

  icache_ctrl_pkg::lookup_state_t state;
  icache_geom_pkg::paddr_t        addr_q;
  icache_ctrl_pkg::mshr_vec_t     first_free;

  assign l0_ready_out = (state == icache_ctrl_pkg::LK_IDLE) && !flush_in;
  assign flush = (state == icache_ctrl_pkg::LK_IDLE) && flush_in;
  assign lookup = l0_valid_in && l0_ready_out;
  assign lookup_addr = l0_addr_in;

  // the array holds its word until the next lookup, which cannot start before LK_IDLE
  assign hit_valid = (state == icache_ctrl_pkg::LK_HIT);
  assign hit_addr = addr_q;
  assign hit_word_out = hit_word;

  assign req_block = addr_q[icache_geom_pkg::PADDR_BITS-1:icache_geom_pkg::OFFSET_BITS];
  assign req_word_sel = addr_q[icache_geom_pkg::OFFSET_BITS-1:icache_geom_pkg::WORD_OFFSET_BITS];
  assign lc_valid_out = (state == icache_ctrl_pkg::LK_SEND_REQ);
  assign lc_addr_out = {req_block, {icache_geom_pkg::OFFSET_BITS{1'b0}}};

  // lowest numbered free queue, one-hot
  always_comb begin
    first_free = '0;
    for (int i = icache_ctrl_pkg::MSHR_COUNT - 1; i >= 0; i--) begin
      if (free[i]) begin
        first_free = icache_ctrl_pkg::mshr_vec_t'(1) << i;
      end
    end
  end

  // secondary miss joins its queue, primary miss takes a fresh one
  always_comb begin
    alloc = '0;
    enqueue = '0;
    if (state == icache_ctrl_pkg::LK_ALLOC) begin
      if (|req_match) begin
        if ((req_match & full) == '0) begin
          enqueue = req_match;
        end
      end else begin
        alloc = first_free;
        enqueue = first_free;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state <= icache_ctrl_pkg::LK_IDLE;
    end else begin
      case (state)
        icache_ctrl_pkg::LK_IDLE: begin
          if (lookup) begin
            state <= icache_ctrl_pkg::LK_LOOKUP;
          end
        end
        icache_ctrl_pkg::LK_LOOKUP: begin
          state <= hit ? icache_ctrl_pkg::LK_HIT : icache_ctrl_pkg::LK_ALLOC;
        end
        icache_ctrl_pkg::LK_HIT: begin
          if (hit_ready) begin
            state <= icache_ctrl_pkg::LK_IDLE;
          end
        end
        icache_ctrl_pkg::LK_ALLOC: begin
          // stays here while the queue is full or none is free
          if (|alloc) begin
            state <= icache_ctrl_pkg::LK_SEND_REQ;
          end else if (|enqueue) begin
            state <= icache_ctrl_pkg::LK_IDLE;
          end
        end
        icache_ctrl_pkg::LK_SEND_REQ: begin
          if (lc_ready_in) begin
            state <= icache_ctrl_pkg::LK_IDLE;
          end
        end
        default: begin
          state <= icache_ctrl_pkg::LK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (lookup) begin
      addr_q <= l0_addr_in;
    end
  end

endmodule

// ==== rtl/icache_responder.sv ====
// a fill with no matching queue is written to the array and produces no response
module icache_responder (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         hit_valid,
  input  icache_geom_pkg::paddr_t      hit_addr,
  input  icache_geom_pkg::word_t       hit_word,
  output logic                         hit_ready,
  input  logic                         lc_valid_in,
  input  icache_geom_pkg::paddr_t      lc_addr_in,
  input  icache_geom_pkg::line_t       lc_value_in,
  output logic                         lc_ready_out,
  output logic                         fill_in,
  output icache_geom_pkg::block_addr_t fill_block,
  output icache_geom_pkg::line_t       fill_line,
  input  icache_ctrl_pkg::mshr_vec_t   fill_match,
  input  icache_geom_pkg::word_sel_t [icache_ctrl_pkg::MSHR_COUNT-1:0] head_word_sel,
  output icache_ctrl_pkg::mshr_vec_t   dequeue,
  output logic                         l0_valid_out,
  output icache_geom_pkg::paddr_t      l0_addr_out,
  output icache_geom_pkg::word_t       l0_value_out,
  input  logic                         l0_ready_in
);

  icache_ctrl_pkg::responder_state_t state;
  icache_geom_pkg::block_addr_t      block_q;
  icache_geom_pkg::line_t            line_q;
  icache_ctrl_pkg::mshr_id_t         queue_q;
  icache_ctrl_pkg::mshr_id_t         match_id;
  icache_geom_pkg::word_sel_t        head_sel;
  logic                              drain_q;
  logic                              pop;

  assign lc_ready_out = (state == icache_ctrl_pkg::RS_IDLE);
  assign fill_in = lc_ready_out && lc_valid_in;
  // fills go first, a waiting hit just stays in LK_HIT
  assign hit_ready = (state == icache_ctrl_pkg::RS_IDLE) && !lc_valid_in;

  // while idle the queues compare against the incoming fill, afterwards against the latched one
  assign fill_block = (state == icache_ctrl_pkg::RS_IDLE) ?
      lc_addr_in[icache_geom_pkg::PADDR_BITS-1:icache_geom_pkg::OFFSET_BITS] : block_q;
  assign fill_line = lc_value_in;

  assign head_sel = head_word_sel[queue_q];
  assign pop = (state == icache_ctrl_pkg::RS_DRAIN) && fill_match[queue_q];
  assign dequeue = pop ? (icache_ctrl_pkg::mshr_vec_t'(1) << queue_q) : '0;

  always_comb begin
    match_id = '0;
    for (int i = icache_ctrl_pkg::MSHR_COUNT - 1; i >= 0; i--) begin
      if (fill_match[i]) begin
        match_id = icache_ctrl_pkg::mshr_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state <= icache_ctrl_pkg::RS_IDLE;
      l0_valid_out <= 1'b0;
      drain_q <= 1'b0;
    end else begin
      case (state)
        icache_ctrl_pkg::RS_IDLE: begin
          if (fill_in) begin
            drain_q <= 1'b1;
            state <= icache_ctrl_pkg::RS_DRAIN;
          end else if (hit_valid) begin
            drain_q <= 1'b0;
            state <= icache_ctrl_pkg::RS_HIT;
          end
        end
        icache_ctrl_pkg::RS_HIT: begin
          l0_valid_out <= 1'b1;
          state <= icache_ctrl_pkg::RS_SEND;
        end
        icache_ctrl_pkg::RS_DRAIN: begin
          // queue goes free after its last pop, which ends the replay
          if (pop) begin
            l0_valid_out <= 1'b1;
            state <= icache_ctrl_pkg::RS_SEND;
          end else begin
            drain_q <= 1'b0;
            state <= icache_ctrl_pkg::RS_IDLE;
          end
        end
        icache_ctrl_pkg::RS_SEND: begin
          if (l0_ready_in) begin
            l0_valid_out <= 1'b0;
            state <= drain_q ? icache_ctrl_pkg::RS_DRAIN : icache_ctrl_pkg::RS_IDLE;
          end
        end
        default: begin
          state <= icache_ctrl_pkg::RS_IDLE;
        end
      endcase
    end
  end

  // latched fill and the response payload
  always_ff @(posedge clk_in) begin
    if (fill_in) begin
      block_q <= fill_block;
      line_q <= lc_value_in;
      queue_q <= match_id;
    end
    if (hit_valid && hit_ready) begin
      l0_addr_out <= hit_addr;
      l0_value_out <= hit_word;
    end else if (pop) begin
      l0_addr_out <= {block_q, head_sel, {icache_geom_pkg::WORD_OFFSET_BITS{1'b0}}};
      l0_value_out <= line_q[head_sel*icache_geom_pkg::WORD_BITS +: icache_geom_pkg::WORD_BITS];
    end
  end

endmodule

// ==== rtl/icache_top.sv ====
// responses may come back out of request order, so L0 must match them by l0_addr_out
module icache_top (
  input  logic                    clk_in,
  input  logic                    rst_N_in,
  input  logic                    flush_in,
  input  logic                    l0_valid_in,
  input  icache_geom_pkg::paddr_t l0_addr_in,
  output logic                    l0_ready_out,
  output logic                    l0_valid_out,
  output icache_geom_pkg::paddr_t l0_addr_out,
  output icache_geom_pkg::word_t  l0_value_out,
  input  logic                    l0_ready_in,
  output logic                    lc_valid_out,
  output icache_geom_pkg::paddr_t lc_addr_out,
  input  logic                    lc_ready_in,
  input  logic                    lc_valid_in,
  input  icache_geom_pkg::paddr_t lc_addr_in,
  input  icache_geom_pkg::line_t  lc_value_in,
  output logic                    lc_ready_out
);

  logic                         lookup;
  icache_geom_pkg::paddr_t      lookup_addr;
  logic                         flush;
  logic                         hit;
  icache_geom_pkg::word_t       hit_word;
  logic                         hit_valid;
  icache_geom_pkg::paddr_t      hit_addr;
  icache_geom_pkg::word_t       hit_word_fwd;
  logic                         hit_ready;
  icache_ctrl_pkg::mshr_vec_t   alloc;
  icache_ctrl_pkg::mshr_vec_t   enqueue;
  icache_ctrl_pkg::mshr_vec_t   dequeue;
  icache_ctrl_pkg::mshr_vec_t   req_match;
  icache_ctrl_pkg::mshr_vec_t   fill_match;
  icache_ctrl_pkg::mshr_vec_t   full;
  icache_ctrl_pkg::mshr_vec_t   free;
  icache_geom_pkg::block_addr_t req_block;
  icache_geom_pkg::word_sel_t   req_word_sel;
  icache_geom_pkg::word_sel_t [icache_ctrl_pkg::MSHR_COUNT-1:0] head_word_sel;
  logic                         fill_in;
  icache_geom_pkg::block_addr_t fill_block;
  icache_geom_pkg::line_t       fill_line;

  icache_array icache_array_inst (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .lookup_in   (lookup),
    .lookup_addr (lookup_addr),
    .fill_in     (fill_in),
    .fill_block  (fill_block),
    .fill_line   (fill_line),
    .flush       (flush),
    .hit         (hit),
    .hit_word    (hit_word)
  );

  icache_lookup_ctrl icache_lookup_ctrl_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .l0_valid_in  (l0_valid_in),
    .l0_addr_in   (l0_addr_in),
    .l0_ready_out (l0_ready_out),
    .flush_in     (flush_in),
    .lookup       (lookup),
    .lookup_addr  (lookup_addr),
    .flush        (flush),
    .hit          (hit),
    .hit_word     (hit_word),
    .hit_valid    (hit_valid),
    .hit_addr     (hit_addr),
    .hit_word_out (hit_word_fwd),
    .hit_ready    (hit_ready),
    .req_match    (req_match),
    .full         (full),
    .free         (free),
    .alloc        (alloc),
    .enqueue      (enqueue),
    .req_block    (req_block),
    .req_word_sel (req_word_sel),
    .lc_valid_out (lc_valid_out),
    .lc_addr_out  (lc_addr_out),
    .lc_ready_in  (lc_ready_in)
  );

  // one miss queue per outstanding block
  for (genvar i = 0; i < icache_ctrl_pkg::MSHR_COUNT; i++) begin : g_mshr
    mshr_queue mshr_queue_inst (
      .clk_in        (clk_in),
      .rst_N_in      (rst_N_in),
      .alloc         (alloc[i]),
      .enqueue       (enqueue[i]),
      .dequeue       (dequeue[i]),
      .req_block     (req_block),
      .req_word_sel  (req_word_sel),
      .fill_block    (fill_block),
      .req_match     (req_match[i]),
      .fill_match    (fill_match[i]),
      .full          (full[i]),
      .free          (free[i]),
      .head_word_sel (head_word_sel[i])
    );
  end

  icache_responder icache_responder_inst (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .hit_valid     (hit_valid),
    .hit_addr      (hit_addr),
    .hit_word      (hit_word_fwd),
    .hit_ready     (hit_ready),
    .lc_valid_in   (lc_valid_in),
    .lc_addr_in    (lc_addr_in),
    .lc_value_in   (lc_value_in),
    .lc_ready_out  (lc_ready_out),
    .fill_in       (fill_in),
    .fill_block    (fill_block),
    .fill_line     (fill_line),
    .fill_match    (fill_match),
    .head_word_sel (head_word_sel),
    .dequeue       (dequeue),
    .l0_valid_out  (l0_valid_out),
    .l0_addr_out   (l0_addr_out),
    .l0_value_out  (l0_value_out),
    .l0_ready_in   (l0_ready_in)
  );

endmodule

// ==== rtl/mshr_queue.sv ====
// enqueue on a full queue or dequeue on an empty one is not guarded here, the controllers avoid it
module mshr_queue (
  input  logic                         clk_in,
  input  logic                         rst_N_in,
  input  logic                         alloc,
  input  logic                         enqueue,
  input  logic                         dequeue,
  input  icache_geom_pkg::block_addr_t req_block,
  input  icache_geom_pkg::word_sel_t   req_word_sel,
  input  icache_geom_pkg::block_addr_t fill_block,
  output logic                         req_match,
  output logic                         fill_match,
  output logic                         full,
  output logic                         free,
  output icache_geom_pkg::word_sel_t   head_word_sel
);

  logic                          busy;
  icache_geom_pkg::block_addr_t  block_q;
  icache_geom_pkg::word_sel_t    fifo [icache_ctrl_pkg::QUEUE_DEPTH];
  icache_ctrl_pkg::queue_ptr_t   rd_ptr;
  icache_ctrl_pkg::queue_ptr_t   wr_ptr;
  icache_ctrl_pkg::queue_count_t count;

  assign free = !busy;
  assign full = (count == icache_ctrl_pkg::QUEUE_DEPTH);
  // a free queue matches nothing, whatever its stale block holds
  assign req_match = busy && (block_q == req_block);
  assign fill_match = busy && (block_q == fill_block);
  assign head_word_sel = fifo[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      busy <= 1'b0;
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (enqueue) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (dequeue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (enqueue && !dequeue) begin
        count <= count + 1'b1;
      end else if (dequeue && !enqueue) begin
        count <= count - 1'b1;
      end
      // a late enqueue on the last pop keeps the queue alive
      if (alloc) begin
        busy <= 1'b1;
      end else if (dequeue && !enqueue && count == 1) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc) begin
      block_q <= req_block;
    end
    if (enqueue) begin
      fifo[wr_ptr] <= req_word_sel;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root; exit status 1 on any failure
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module icache_tb \
  -o icache_sim > build.log 2>&1 \
  && ./obj_dir/icache_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

// ==== testbench/icache_checker.sv ====
// bound into icache_top, checks only the outside handshakes
module icache_checker (
  input logic                    clk_in,
  input logic                    rst_N_in,
  input logic                    l0_valid_out,
  input icache_geom_pkg::paddr_t l0_addr_out,
  input icache_geom_pkg::word_t  l0_value_out,
  input logic                    l0_ready_in,
  input logic                    lc_valid_out,
  input icache_geom_pkg::paddr_t lc_addr_out,
  input logic                    lc_ready_in
);

  // response held until taken
  a_l0_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
      l0_valid_out && !l0_ready_in |=>
      l0_valid_out && $stable(l0_addr_out) && $stable(l0_value_out))
    else $error("l0 response changed before l0_ready_in");

  a_lc_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
      lc_valid_out && !lc_ready_in |=> lc_valid_out && $stable(lc_addr_out))
    else $error("lower cache request changed before lc_ready_in");

  // block requests are line aligned
  a_lc_aligned: assert property (@(posedge clk_in) disable iff (!rst_N_in)
      lc_valid_out |-> lc_addr_out[icache_geom_pkg::OFFSET_BITS-1:0] == '0)
    else $error("lc_addr_out has offset bits set");

  a_reset_quiet: assert property (@(posedge clk_in)
      $rose(rst_N_in) |-> !l0_valid_out && !lc_valid_out)
    else $error("valid high right after reset release");

endmodule

// ==== testbench/icache_golden.txt ====
// one hex entry per line: cmd (1 request, 2 flush, 3 wait idle), 24-bit address, 64-bit word
// for wait idle the word is the expected lower cache request count since the last wait, FF skips it
10001005A5A0000C3C30020
10002005A5A0000C3C30040
10002085A5A0000C3C30041
10002105A5A0000C3C30042
10002185A5A0000C3C30043
30000000000000000000002
10001005A5A0000C3C30020
10002085A5A0000C3C30041
10001005A5A0000C3C30020
30000000000000000000000
20000000000000000000000
30000000000000000000000
10001005A5A0000C3C30020
30000000000000000000001
10010005A5A0000C3C30200
10020205A5A0000C3C30404
10030405A5A0000C3C30608
10040605A5A0000C3C3080C
10050005A5A0000C3C30A00
10060005A5A0000C3C30C00
10060085A5A0000C3C30C01
10060105A5A0000C3C30C02
10060185A5A0000C3C30C03
10060005A5A0000C3C30C00
300000000000000000000FF

// ==== testbench/icache_tb.sv ====
// golden file path is relative to the run directory; the lower cache serves one block at a time
module icache_tb;

  localparam logic [63:0] MEM_MASK = 64'h5A5A_0000_C3C3_0000;

  logic                    clk_in;
  logic                    rst_N_in;
  logic                    flush_in;
  logic                    l0_valid_in;
  icache_geom_pkg::paddr_t l0_addr_in;
  logic                    l0_ready_out;
  logic                    l0_valid_out;
  icache_geom_pkg::paddr_t l0_addr_out;
  icache_geom_pkg::word_t  l0_value_out;
  logic                    l0_ready_in;
  logic                    lc_valid_out;
  icache_geom_pkg::paddr_t lc_addr_out;
  logic                    lc_ready_in;
  logic                    lc_valid_in;
  icache_geom_pkg::paddr_t lc_addr_in;
  icache_geom_pkg::line_t  lc_value_in;
  logic                    lc_ready_out;

  // cmd nibble, 24-bit address field, 64-bit word
  logic [91:0] golden [0:63];
  integer      seed = 48;
  integer      value_errors = 0;
  integer      other_errors = 0;
  integer      cycle_count = 0;
  integer      cycle_limit = 100000;
  integer      lc_req_count = 0;
  integer      fill_delay = 0;
  logic        fill_armed = 1'b0;

  icache_geom_pkg::paddr_t exp_addr_q[$];
  icache_geom_pkg::word_t  exp_word_q[$];
  icache_geom_pkg::paddr_t lc_queue[$];

  icache_top icache_top_inst (.*);

  bind icache_top icache_checker icache_checker_inst (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .l0_valid_out (l0_valid_out),
    .l0_addr_out  (l0_addr_out),
    .l0_value_out (l0_value_out),
    .l0_ready_in  (l0_ready_in),
    .lc_valid_out (lc_valid_out),
    .lc_addr_out  (lc_addr_out),
    .lc_ready_in  (lc_ready_in)
  );

  always #50 clk_in = ~clk_in;

  // memory word at word address w is w xor the mask
  function automatic icache_geom_pkg::line_t build_line(icache_geom_pkg::paddr_t block);
    icache_geom_pkg::line_t line;
    logic [63:0]            w;
    for (int i = 0; i < 4; i++) begin
      w = 64'(block >> 3) + 64'(i);
      line[i*64 +: 64] = w ^ MEM_MASK;
    end
    return line;
  endfunction

  // lower cache model with random request stalls and a 1 to 8 cycle answer delay
  always @(posedge clk_in) begin
    if (rst_N_in) begin
      l0_ready_in <= ($random(seed) & 3) != 0;
      lc_ready_in <= ($random(seed) & 3) != 0;
      if (lc_valid_out && lc_ready_in) begin
        lc_queue.push_back(lc_addr_out);
        lc_req_count = lc_req_count + 1;
      end
      if (lc_valid_in) begin
        if (lc_ready_out) begin
          lc_valid_in <= 1'b0;
        end
      end else if (lc_queue.size() != 0) begin
        if (!fill_armed) begin
          fill_delay = 1 + ($unsigned($random(seed)) % 8);
          fill_armed = 1'b1;
        end else if (fill_delay > 1) begin
          fill_delay = fill_delay - 1;
        end else begin
          lc_valid_in <= 1'b1;
          lc_addr_in <= lc_queue[0];
          lc_value_in <= build_line(lc_queue[0]);
          lc_queue.delete(0);
          fill_armed = 1'b0;
        end
      end
    end
  end

  // response check against the outstanding list
  always @(posedge clk_in) begin
    int idx;
    idx = -1;
    if (rst_N_in && l0_valid_out && l0_ready_in) begin
      for (int i = exp_addr_q.size() - 1; i >= 0; i--) begin
        if (exp_addr_q[i] == l0_addr_out) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        $display("response for address %h that was never requested", l0_addr_out);
        other_errors = other_errors + 1;
      end else begin
        if (l0_value_out != exp_word_q[idx]) begin
          $display("ERR t=%0t l0_value_out exp=%h got=%h", $time, exp_word_q[idx], l0_value_out);
          value_errors = value_errors + 1;
        end
        exp_addr_q.delete(idx);
        exp_word_q.delete(idx);
      end
    end
  end

  always @(posedge clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      other_errors = other_errors + 1;
      $display("run timed out after %0d cycles with %0d requests never answered",
               cycle_count, exp_addr_q.size());
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic send_request(icache_geom_pkg::paddr_t addr, icache_geom_pkg::word_t word);
    @(posedge clk_in);
    l0_valid_in <= 1'b1;
    l0_addr_in <= addr;
    do @(posedge clk_in); while (!l0_ready_out);
    exp_addr_q.push_back(addr);
    exp_word_q.push_back(word);
    l0_valid_in <= 1'b0;
  endtask

  // looks between edges, once the model and the response check have settled
  task automatic wait_idle();
    @(negedge clk_in);
    while (exp_addr_q.size() != 0 || lc_queue.size() != 0 || lc_valid_in || !l0_ready_out) begin
      @(negedge clk_in);
    end
  endtask

  initial begin
    int n;
    int last_count;
    clk_in = 1'b0;
    rst_N_in = 1'b0;
    flush_in = 1'b0;
    l0_valid_in = 1'b0;
    l0_addr_in = '0;
    l0_ready_in = 1'b0;
    lc_ready_in = 1'b0;
    lc_valid_in = 1'b0;
    lc_addr_in = '0;
    lc_value_in = '0;
    for (int i = 0; i < 64; i++) begin
      golden[i] = '0;
    end
    $readmemh("testbench/icache_golden.txt", golden);
    n = 0;
    while (n < 64 && golden[n][91:88] != 4'h0) begin
      n = n + 1;
    end
    cycle_limit = n * 64 + 100;
    last_count = 0;
    repeat (2) @(posedge clk_in);
    rst_N_in <= 1'b1;
    for (int c = 0; c < n; c++) begin
      case (golden[c][91:88])
        4'h1: send_request(golden[c][85:64], golden[c][63:0]);
        4'h2: begin
          @(posedge clk_in);
          flush_in <= 1'b1;
          @(posedge clk_in);
          flush_in <= 1'b0;
        end
        default: begin
          wait_idle();
          // FF in the word field skips the request count check
          if (golden[c][7:0] != 8'hFF && lc_req_count - last_count != golden[c][7:0]) begin
            $display("ERR t=%0t lc_valid_out requests exp=%0d got=%0d", $time,
                     golden[c][7:0], lc_req_count - last_count);
            value_errors = value_errors + 1;
          end
          last_count = lc_req_count;
        end
      endcase
    end
    wait_idle();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
